// File: Bender.yml
package:
  name: aluSubsystem

sources:
  - rtl/aluPkg.sv
  - rtl/addSubUnit.sv
  - rtl/shiftUnit.sv
  - rtl/logicCompareUnit.sv
  - rtl/aluRegControl.sv
  - rtl/aluSubsystem.sv
  - target: test
    files:
      - dv/aluSubsystem_props.sv
      - dv/aluSubsystemTb.sv

// File: aluSubsystem.f
rtl/aluPkg.sv
rtl/addSubUnit.sv
rtl/shiftUnit.sv
rtl/logicCompareUnit.sv
rtl/aluRegControl.sv
rtl/aluSubsystem.sv
dv/aluSubsystem_props.sv
dv/aluSubsystemTb.sv

// File: dv/aluSubsystemTb.sv
`timescale 1ns/1ps

module aluSubsystemTb;
	import aluPkg::*;

	localparam int DataWidth = 32;
	localparam int AddrWidth = 5;
	// Reset reads, 126 operations of five transfers each, error cases and two stalled transfers.
	localparam int Transfers = 5 + 5 * 126 + 17 + 2;
	localparam int CycleLimit = 20 * Transfers + 100;

	logic clk = 1'b0;
	logic reset;
	logic [AddrWidth-1:0] awAddr;
	logic awValid;
	logic awReady;
	logic [DataWidth-1:0] wData;
	logic [DataWidth/8-1:0] wStrb;
	logic wValid;
	logic wReady;
	logic [1:0] bResp;
	logic bValid;
	logic bReady;
	logic [AddrWidth-1:0] arAddr;
	logic arValid;
	logic arReady;
	logic [DataWidth-1:0] rData;
	logic [1:0] rResp;
	logic rValid;
	logic rReady;

	int errorCount = 0;
	int cycleCount = 0;
	logic [31:0] rngState = 32'hcccd_25ab;
	logic [31:0] corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};

	aluSubsystem #(
		.DataWidth(DataWidth),
		.AddrWidth(AddrWidth)
	) u_aluSubsystem (.*);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > CycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("Check errors: %0d, property errors: %0d", errorCount,
				u_aluSubsystem.propsCheck.failCount);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Expected flags word in the top five bits, result below.
	function automatic logic [36:0] expectedOutcome(input aluOp_t op, input logic [1:0] amt,
		input logic [31:0] a, input logic [31:0] b);
		logic [32:0] wide;
		logic [31:0] r;
		logic [4:0] flags;
		flags = '0;
		flags[FlagDone] = 1'b1;
		r = '0;
		case (op)
			OpAdd, OpSub:
			begin
				wide = (op == OpAdd) ? {1'b0, a} + {1'b0, b} : {1'b0, a} - {1'b0, b};
				r = wide[31:0];
				// Bit 32 is the carry for add and the borrow for subtract.
				flags[FlagCarry] = wide[32];
				flags[FlagOverflow] = (op == OpAdd) ? (a[31] == b[31] && r[31] != a[31])
					: (a[31] != b[31] && r[31] != a[31]);
				flags[FlagZero] = (r == '0) && !flags[FlagOverflow];
				flags[FlagNegative] = r[31];
			end
			OpShl:
			begin
				r = a << amt;
				flags[FlagCarry] = (amt == 2'd0) ? 1'b0 : a[32 - amt];
				flags[FlagZero] = (r == '0);
				flags[FlagNegative] = r[31];
			end
			OpSlt: r = (a < b) ? 32'd1 : 32'd0;
			OpAnd: r = a & b;
			OpOr: r = a | b;
			OpXor: r = a ^ b;
			default: r = '0;
		endcase
		if (op == OpAnd || op == OpOr || op == OpXor)
			flags[FlagZero] = (r == '0);
		return {flags, r};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic axiWrite(input string name, input logic [4:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] expResp, input int hold);
		logic awHit;
		logic wHit;
		logic [1:0] resp;
		awAddr = addr;
		wData = data;
		wStrb = strb;
		awValid = 1'b1;
		wValid = 1'b1;
		while (awValid || wValid)
		begin
			awHit = awValid && awReady;
			wHit = wValid && wReady;
			@(negedge clk);
			if (awHit)
				awValid = 1'b0;
			if (wHit)
				wValid = 1'b0;
		end
		while (!bValid)
			@(negedge clk);
		resp = bResp;
		repeat (hold)
		begin
			@(negedge clk);
			assert (bValid && bResp === resp && !awReady && !wReady)
			else
			begin
				errorCount++;
				$display("%s: write response changed or a new write was taken while stalled", name);
			end
		end
		bReady = 1'b1;
		@(negedge clk);
		bReady = 1'b0;
		checkValue({name, " bResp"}, 32'(expResp), 32'(resp));
	endtask

	task automatic axiRead(input string name, input logic [4:0] addr,
		input logic [31:0] expData, input logic [1:0] expResp, input int hold);
		logic hit;
		logic [31:0] data;
		logic [1:0] resp;
		arAddr = addr;
		arValid = 1'b1;
		while (arValid)
		begin
			hit = arReady;
			@(negedge clk);
			if (hit)
				arValid = 1'b0;
		end
		while (!rValid)
			@(negedge clk);
		data = rData;
		resp = rResp;
		repeat (hold)
		begin
			@(negedge clk);
			assert (rValid && rData === data && rResp === resp && !arReady)
			else
			begin
				errorCount++;
				$display("%s: read response changed or a new read was taken while stalled", name);
			end
		end
		rReady = 1'b1;
		@(negedge clk);
		rReady = 1'b0;
		checkValue({name, " rData"}, expData, data);
		checkValue({name, " rResp"}, 32'(expResp), 32'(resp));
	endtask

	task automatic runOp(input string name, input aluOp_t op, input logic [1:0] amt,
		input logic [31:0] a, input logic [31:0] b);
		logic [36:0] expected;
		string tag;
		expected = expectedOutcome(op, amt, a, b);
		tag = $sformatf("%s a=%h b=%h amt=%0d", name, a, b, amt);
		axiWrite(tag, RegOperandA, a, 4'hf, RespOkay, 0);
		axiWrite(tag, RegOperandB, b, 4'hf, RespOkay, 0);
		axiWrite(tag, RegCommand, (32'(op) << CmdOpLsb) | (32'(amt) << CmdAmountLsb), 4'hf,
			RespOkay, 0);
		axiRead({tag, " result"}, RegResult, expected[31:0], RespOkay, 0);
		axiRead({tag, " flags"}, RegFlags, 32'(expected[36:32]), RespOkay, 0);
	endtask

	initial
	begin
		logic [31:0] a;
		logic [31:0] b;
		reset = 1'b1;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wStrb = '0;
		wValid = 1'b0;
		bReady = 1'b0;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < 5; i++)
			axiRead("reset", 5'(4 * i), 32'h0, RespOkay, 0);

		for (int i = 0; i < 5; i++)
			for (int j = 0; j < 5; j++)
			begin
				runOp("add", OpAdd, 2'd0, corners[i], corners[j]);
				runOp("sub", OpSub, 2'd0, corners[i], corners[j]);
			end
		for (int i = 0; i < 8; i++)
		begin
			a = nextRandom();
			b = nextRandom();
			runOp("add", OpAdd, 2'd0, a, b);
			runOp("sub", OpSub, 2'd0, a, b);
		end

		for (int s = 0; s < 4; s++)
			for (int i = 0; i < 8; i++)
				runOp("shl", OpShl, 2'(s), (i < 5) ? corners[i] : nextRandom(), 32'h0);

		for (int k = 4; k < 7; k++)
			for (int i = 0; i < 8; i++)
				if (i < 5)
					runOp("logic", aluOp_t'(k), 2'd0, corners[i], corners[4 - i]);
				else
					runOp("logic", aluOp_t'(k), 2'd0, nextRandom(), nextRandom());

		a = nextRandom();
		runOp("slt equal", OpSlt, 2'd0, a, a);
		runOp("slt", OpSlt, 2'd0, 32'h8000_0000, 32'h1);
		runOp("slt", OpSlt, 2'd0, 32'h1, 32'h8000_0000);
		runOp("slt", OpSlt, 2'd0, nextRandom(), nextRandom());

		// Rejected writes must leave the 5 plus 7 result in place.
		runOp("base", OpAdd, 2'd0, 32'd5, 32'd7);
		axiWrite("illegal op", RegCommand, 32'h7, 4'hf, RespSlvErr, 0);
		axiWrite("write result", RegResult, 32'hffff_ffff, 4'hf, RespSlvErr, 0);
		axiWrite("write flags", RegFlags, 32'hffff_ffff, 4'hf, RespSlvErr, 0);
		for (int i = 5; i < 8; i++)
			axiWrite("unmapped write", 5'(4 * i), 32'h1, 4'hf, RespSlvErr, 0);
		axiRead("unmapped read", 5'h14, 32'h0, RespSlvErr, 0);
		axiRead("kept result", RegResult, 32'd12, RespOkay, 0);
		axiRead("kept flags", RegFlags, 32'(1) << FlagDone, RespOkay, 0);
		axiRead("kept command", RegCommand, 32'(OpAdd), RespOkay, 0);
		axiWrite("partial strobe", RegOperandA, 32'hdead_beef, 4'b0111, RespOkay, 0);
		axiRead("partial strobe", RegOperandA, 32'd5, RespOkay, 0);

		axiWrite("stalled write", RegOperandB, 32'h1234_5678, 4'hf, RespOkay, 4);
		axiRead("stalled read", RegOperandB, 32'h1234_5678, RespOkay, 4);

		@(negedge clk);
		$display("Check errors: %0d, property errors: %0d", errorCount,
			u_aluSubsystem.propsCheck.failCount);
		if (errorCount == 0 && u_aluSubsystem.propsCheck.failCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: dv/aluSubsystem_props.sv
`timescale 1ns/1ps

module aluSubsystem_props #(
	parameter int DataWidth = 32
) (
	input logic                 clk,
	input logic                 reset,
	input logic                 awReady,
	input logic                 wReady,
	input logic [1:0]           bResp,
	input logic                 bValid,
	input logic                 bReady,
	input logic                 arValid,
	input logic                 arReady,
	input logic [DataWidth-1:0] rData,
	input logic [1:0]           rResp,
	input logic                 rValid,
	input logic                 rReady
);

	int failCount = 0;

	// Responses keep valid and payload until the handshake.
	responseHold: assert property (@(posedge clk) disable iff (reset)
		(bValid && !bReady |=> bValid && $stable(bResp))
		and (rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp)))
	else
	begin
		failCount++;
		$error("A response valid dropped or its payload changed before the handshake");
	end

	resetState: assert property (@(posedge clk) reset |=> !bValid && !rValid)
	else
	begin
		failCount++;
		$error("bValid or rValid is high after reset");
	end

	// Read data comes exactly one cycle after the address capture.
	readLatency: assert property (@(posedge clk) disable iff (reset)
		(arValid && arReady |=> rValid) and ($rose(rValid) |-> $past(arValid && arReady)))
	else
	begin
		failCount++;
		$error("rValid did not follow the read address capture by one cycle");
	end

	writeStall: assert property (@(posedge clk) disable iff (reset)
		bValid |-> !awReady && !wReady)
	else
	begin
		failCount++;
		$error("Write channel accepted a request while a response was pending");
	end

endmodule

bind aluSubsystem aluSubsystem_props #(
	.DataWidth(DataWidth)
) propsCheck (.*);

// File: rtl/addSubUnit.sv
`timescale 1ns/1ps

module addSubUnit #(
	parameter int DataWidth = 32
) (
	input  logic [DataWidth-1:0] operandA,
	input  logic [DataWidth-1:0] operandB,
	input  aluPkg::aluOp_t       op,
	output logic [DataWidth-1:0] sumResult,
	output logic                 addZero,
	output logic                 addOverflow,
	output logic                 addCarry,
	output logic                 addNegative
);
	import aluPkg::*;

	logic                 isSub;
	logic [DataWidth-1:0] addend;
	logic [DataWidth:0]   carry;

	// Subtract is A plus the inverted B plus one.
	assign isSub = (op == OpSub);
	assign addend = isSub ? ~operandB : operandB;
	assign carry[0] = isSub;

	genvar i;
	generate
		for (i = 0; i < DataWidth; i = i + 1)
		begin : rippleChain
			assign sumResult[i] = operandA[i] ^ addend[i] ^ carry[i];
			assign carry[i+1] = (operandA[i] & addend[i]) | (carry[i] & (operandA[i] ^ addend[i]));
		end
	endgenerate

	// Borrow is the inverse of the carry out.
	assign addCarry = isSub ? ~carry[DataWidth] : carry[DataWidth];
	assign addOverflow = carry[DataWidth] != carry[DataWidth-1];
	assign addZero = !addOverflow && (sumResult == '0);
	assign addNegative = sumResult[DataWidth-1];

endmodule

// File: rtl/aluPkg.sv
package aluPkg;

	// Operation codes carried in the low bits of the command word.
	typedef enum logic [2:0] {
		OpAdd = 3'd0,
		OpSub = 3'd1,
		OpShl = 3'd2,
		OpSlt = 3'd3,
		OpAnd = 3'd4,
		OpOr  = 3'd5,
		OpXor = 3'd6
	} aluOp_t;

	// Register byte offsets.
	localparam logic [4:0] RegOperandA = 5'h00;
	localparam logic [4:0] RegOperandB = 5'h04;
	localparam logic [4:0] RegCommand  = 5'h08;
	localparam logic [4:0] RegResult   = 5'h0C;
	localparam logic [4:0] RegFlags    = 5'h10;

	// Command word fields.
	localparam int CmdOpLsb     = 0;
	localparam int CmdAmountLsb = 4;

	// Bit positions in the flags register.
	localparam int FlagZero     = 0;
	localparam int FlagOverflow = 1;
	localparam int FlagCarry    = 2;
	localparam int FlagNegative = 3;
	localparam int FlagDone     = 4;

	localparam logic [1:0] RespOkay   = 2'b00;
	localparam logic [1:0] RespSlvErr = 2'b10;

endpackage

// File: rtl/aluRegControl.sv
`timescale 1ns/1ps

module aluRegControl #(
	parameter int DataWidth = 32,
	parameter int AddrWidth = 5
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [AddrWidth-1:0]   awAddr,
	input  logic                   awValid,
	output logic                   awReady,
	input  logic [DataWidth-1:0]   wData,
	input  logic [DataWidth/8-1:0] wStrb,
	input  logic                   wValid,
	output logic                   wReady,
	output logic [1:0]             bResp,
	output logic                   bValid,
	input  logic                   bReady,
	input  logic [AddrWidth-1:0]   arAddr,
	input  logic                   arValid,
	output logic                   arReady,
	output logic [DataWidth-1:0]   rData,
	output logic [1:0]             rResp,
	output logic                   rValid,
	input  logic                   rReady,
	output logic [DataWidth-1:0]   operandA,
	output logic [DataWidth-1:0]   operandB,
	output aluPkg::aluOp_t         op,
	output logic [1:0]             amount,
	input  logic [DataWidth-1:0]   sumResult,
	input  logic                   addZero,
	input  logic                   addOverflow,
	input  logic                   addCarry,
	input  logic                   addNegative,
	input  logic [DataWidth-1:0]   shiftResult,
	input  logic                   shiftZero,
	input  logic                   shiftCarry,
	input  logic                   shiftNegative,
	input  logic [DataWidth-1:0]   logicResult,
	input  logic                   logicZero
);
	import aluPkg::*;

	logic [AddrWidth-1:0]   awAddrHeld;
	logic                   awFull;
	logic [DataWidth-1:0]   wDataHeld;
	logic [DataWidth/8-1:0] wStrbHeld;
	logic                   wFull;
	logic                   writeNow;
	logic                   writeErr;
	logic                   fullStrobe;
	logic                   cmdIllegal;
	logic                   cmdPending;
	logic [DataWidth-1:0]   result;
	logic [FlagDone:0]      flags;
	logic [DataWidth-1:0]   nextResult;
	logic [FlagNegative:0]  nextFlags;
	logic [DataWidth-1:0]   readData;
	logic                   readErr;

	// Address and data are taken separately; the write runs once both are held.
	assign awReady = !bValid && !awFull;
	assign wReady = !bValid && !wFull;
	assign writeNow = awFull && wFull;
	assign fullStrobe = &wStrbHeld;
	assign cmdIllegal = wDataHeld[CmdOpLsb +: 3] > OpXor;
	assign arReady = !rValid;

	always_comb
	begin
		case (awAddrHeld)
			AddrWidth'(RegOperandA): writeErr = 1'b0;
			AddrWidth'(RegOperandB): writeErr = 1'b0;
			AddrWidth'(RegCommand): writeErr = cmdIllegal;
			default: writeErr = 1'b1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awFull <= 1'b0;
			wFull <= 1'b0;
			bValid <= 1'b0;
		end
		else
		begin
			if (awValid && awReady)
				awFull <= 1'b1;
			else if (writeNow)
				awFull <= 1'b0;
			if (wValid && wReady)
				wFull <= 1'b1;
			else if (writeNow)
				wFull <= 1'b0;
			if (writeNow)
				bValid <= 1'b1;
			else if (bReady)
				bValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (awValid && awReady)
			awAddrHeld <= awAddr;
		if (wValid && wReady)
		begin
			wDataHeld <= wData;
			wStrbHeld <= wStrb;
		end
		if (writeNow)
			bResp <= writeErr ? RespSlvErr : RespOkay;
	end

	// Pick the unit that matches the stored command.
	always_comb
	begin
		nextResult = logicResult;
		nextFlags = '0;
		case (op)
			OpAdd, OpSub:
			begin
				nextResult = sumResult;
				nextFlags[FlagZero] = addZero;
				nextFlags[FlagOverflow] = addOverflow;
				nextFlags[FlagCarry] = addCarry;
				nextFlags[FlagNegative] = addNegative;
			end
			OpShl:
			begin
				nextResult = shiftResult;
				nextFlags[FlagZero] = shiftZero;
				nextFlags[FlagCarry] = shiftCarry;
				nextFlags[FlagNegative] = shiftNegative;
			end
			default:
				nextFlags[FlagZero] = logicZero;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			operandA <= '0;
			operandB <= '0;
			op <= OpAdd;
			amount <= '0;
			cmdPending <= 1'b0;
			result <= '0;
			flags <= '0;
		end
		else
		begin
			// Writes with a partial strobe are dropped.
			if (writeNow && !writeErr && fullStrobe)
			begin
				case (awAddrHeld)
					AddrWidth'(RegOperandA): operandA <= wDataHeld;
					AddrWidth'(RegOperandB): operandB <= wDataHeld;
					default:
					begin
						op <= aluOp_t'(wDataHeld[CmdOpLsb +: 3]);
						amount <= wDataHeld[CmdAmountLsb +: 2];
						flags[FlagDone] <= 1'b0;
						cmdPending <= 1'b1;
					end
				endcase
			end
			if (cmdPending)
			begin
				result <= nextResult;
				flags[FlagNegative:0] <= nextFlags;
				flags[FlagDone] <= 1'b1;
				cmdPending <= 1'b0;
			end
		end
	end

	always_comb
	begin
		readData = '0;
		readErr = 1'b0;
		case (arAddr)
			AddrWidth'(RegOperandA): readData = operandA;
			AddrWidth'(RegOperandB): readData = operandB;
			AddrWidth'(RegCommand):
			begin
				readData[CmdOpLsb +: 3] = op;
				readData[CmdAmountLsb +: 2] = amount;
			end
			AddrWidth'(RegResult): readData = result;
			AddrWidth'(RegFlags): readData[FlagDone:0] = flags;
			default: readErr = 1'b1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rValid <= 1'b0;
		else if (arValid && arReady)
			rValid <= 1'b1;
		else if (rReady)
			rValid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (arValid && arReady)
		begin
			rData <= readData;
			rResp <= readErr ? RespSlvErr : RespOkay;
		end
	end

endmodule

// File: rtl/aluSubsystem.sv
`timescale 1ns/1ps

module aluSubsystem #(
	parameter int DataWidth = 32,
	parameter int AddrWidth = 5
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [AddrWidth-1:0]   awAddr,
	input  logic                   awValid,
	output logic                   awReady,
	input  logic [DataWidth-1:0]   wData,
	input  logic [DataWidth/8-1:0] wStrb,
	input  logic                   wValid,
	output logic                   wReady,
	output logic [1:0]             bResp,
	output logic                   bValid,
	input  logic                   bReady,
	input  logic [AddrWidth-1:0]   arAddr,
	input  logic                   arValid,
	output logic                   arReady,
	output logic [DataWidth-1:0]   rData,
	output logic [1:0]             rResp,
	output logic                   rValid,
	input  logic                   rReady
);
	import aluPkg::*;

	logic [DataWidth-1:0] operandA;
	logic [DataWidth-1:0] operandB;
	aluOp_t               op;
	logic [1:0]           amount;
	logic [DataWidth-1:0] sumResult;
	logic                 addZero;
	logic                 addOverflow;
	logic                 addCarry;
	logic                 addNegative;
	logic [DataWidth-1:0] shiftResult;
	logic                 shiftZero;
	logic                 shiftCarry;
	logic                 shiftNegative;
	logic [DataWidth-1:0] logicResult;
	logic                 logicZero;

	aluRegControl #(
		.DataWidth(DataWidth),
		.AddrWidth(AddrWidth)
	) u_aluRegControl (
		.clk(clk),
		.reset(reset),
		.awAddr(awAddr),
		.awValid(awValid),
		.awReady(awReady),
		.wData(wData),
		.wStrb(wStrb),
		.wValid(wValid),
		.wReady(wReady),
		.bResp(bResp),
		.bValid(bValid),
		.bReady(bReady),
		.arAddr(arAddr),
		.arValid(arValid),
		.arReady(arReady),
		.rData(rData),
		.rResp(rResp),
		.rValid(rValid),
		.rReady(rReady),
		.operandA(operandA),
		.operandB(operandB),
		.op(op),
		.amount(amount),
		.sumResult(sumResult),
		.addZero(addZero),
		.addOverflow(addOverflow),
		.addCarry(addCarry),
		.addNegative(addNegative),
		.shiftResult(shiftResult),
		.shiftZero(shiftZero),
		.shiftCarry(shiftCarry),
		.shiftNegative(shiftNegative),
		.logicResult(logicResult),
		.logicZero(logicZero)
	);

	addSubUnit #(
		.DataWidth(DataWidth)
	) u_addSubUnit (
		.operandA(operandA),
		.operandB(operandB),
		.op(op),
		.sumResult(sumResult),
		.addZero(addZero),
		.addOverflow(addOverflow),
		.addCarry(addCarry),
		.addNegative(addNegative)
	);

	shiftUnit #(
		.DataWidth(DataWidth)
	) u_shiftUnit (
		.operandA(operandA),
		.amount(amount),
		.shiftResult(shiftResult),
		.shiftZero(shiftZero),
		.shiftCarry(shiftCarry),
		.shiftNegative(shiftNegative)
	);

	logicCompareUnit #(
		.DataWidth(DataWidth)
	) u_logicCompareUnit (
		.operandA(operandA),
		.operandB(operandB),
		.op(op),
		.logicResult(logicResult),
		.logicZero(logicZero)
	);

endmodule

// File: rtl/logicCompareUnit.sv
`timescale 1ns/1ps

module logicCompareUnit #(
	parameter int DataWidth = 32
) (
	input  logic [DataWidth-1:0] operandA,
	input  logic [DataWidth-1:0] operandB,
	input  aluPkg::aluOp_t       op,
	output logic [DataWidth-1:0] logicResult,
	output logic                 logicZero
);
	import aluPkg::*;

	always_comb
	begin
		logicResult = '0;
		case (op)
			OpAnd: logicResult = operandA & operandB;
			OpOr: logicResult = operandA | operandB;
			OpXor: logicResult = operandA ^ operandB;
			// Unsigned compare.
			OpSlt: logicResult[0] = operandA < operandB;
			default: logicResult = '0;
		endcase
	end

	// Set-less-than reports no flags.
	assign logicZero = (op != OpSlt) && (logicResult == '0);

endmodule

// File: rtl/shiftUnit.sv
`timescale 1ns/1ps

module shiftUnit #(
	parameter int DataWidth = 32
) (
	input  logic [DataWidth-1:0] operandA,
	input  logic [1:0]           amount,
	output logic [DataWidth-1:0] shiftResult,
	output logic                 shiftZero,
	output logic                 shiftCarry,
	output logic                 shiftNegative
);

	assign shiftResult = operandA << amount;

	// Carry is the last bit pushed out the top.
	always_comb
	begin
		case (amount)
			2'd0: shiftCarry = 1'b0;
			2'd1: shiftCarry = operandA[DataWidth-1];
			2'd2: shiftCarry = operandA[DataWidth-2];
			default: shiftCarry = operandA[DataWidth-3];
		endcase
	end

	assign shiftZero = (shiftResult == '0);
	assign shiftNegative = shiftResult[DataWidth-1];

endmodule
